/* tests/fme_stimulus.txt */
// one test per line, hex words:
// partition  table_seed  half_delay  quar_delay  idx_of_2nd_read  idx_of_5th_read
// a delay of 0 is replaced by a random wait of 1 to 32 cycles
00000000000 0011 3  0  1 4
2AAAAAAAAAA 7A3C 0  11 2 8
0123456789A 1234 1  0  2 8
3FFC50F1D24 0BEE 0  0  1 4

/* tb.f */
+incdir+hdl
hdl/fme_part_pkg.sv
hdl/fme_ctrl_pkg.sv
hdl/fme_phase_fsm.sv
hdl/fme_blk_walker.sv
hdl/fme_mv_route.sv
hdl/fme_ctrl_top.sv
tests/fme_ctrl_sva.sv
tests/fme_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the fractional ME controller

VERILATOR ?= verilator
TOP       ?= fme_ctrl_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TB PASSED

SRCS := $(shell grep -v '^+' tb.f)
HDRS := hdl/fme_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) tb.f
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_STR)$$"

clean:
	rm -rf $(OBJ_DIR)

/* tests/fme_ctrl_tb.sv */
/*
 * testbench for fme_ctrl_top to be run from the project root
 * each test gives a partition, a table seed, two cost delays (0 = random)
 * and the expected indices of the 2nd and 5th block read
 */
`include "fme_consts.svh"
`default_nettype none

module fme_ctrl_tb;

    localparam int NTESTS = 4;
    localparam int NCOLS  = 6;

    logic clk;
    logic rstn;
    logic start_i;
    logic cost_done_i;
    logic [`FME_PART_W-1:0] partition_i;
    logic done_o, imv_rden_o, fmv_rden_o, ref_rden_o, ip_start_o, ip_half_flag_o;
    logic [`FME_BLK_W-1:0] imv_rdaddr_o, fmv_rdaddr_o, ip_idx_o;
    logic [2*`FME_MV_W-1:0] imv_data_i, fmv_data_i;
    logic [`FME_REF_W-1:0] ref_idx_x_o, ref_idx_y_o;
    logic [`FME_MV_W-1:0] ip_mv_x_o, ip_mv_y_o;
    logic [1:0] ip_frac_x_o, ip_frac_y_o;

    logic [63:0] stim [NTESTS*NCOLS];
    logic [2*`FME_MV_W-1:0] imv_mem [64];
    logic [2*`FME_MV_W-1:0] fmv_mem [64];
    int imv_x [64], imv_y [64], fmv_x [64], fmv_y [64];
    int order [64];
    int delay [NTESTS][2];
    int cycles;
    int limit;
    int seed_ret;

    fme_ctrl_top fme_ctrl_top_inst (.*);

    // vector memories answer combinationally on the shared address
    assign imv_data_i = imv_mem[imv_rdaddr_o];
    assign fmv_data_i = fmv_mem[fmv_rdaddr_o];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
            $display("TB FAILED");
            $fatal(1);
        end else if (fme_ctrl_top_inst.fme_ctrl_sva_inst.fail_cnt != 0) begin
            $display("ERROR: a bound assertion on the DUT strobes failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic expect_quiet();
        check("imv_rden_o", 64'(imv_rden_o), 64'd0);
        check("fmv_rden_o", 64'(fmv_rden_o), 64'd0);
        check("ref_rden_o", 64'(ref_rden_o), 64'd0);
        check("ip_start_o", 64'(ip_start_o), 64'd0);
        check("done_o", 64'(done_o), 64'd0);
    endtask

    function automatic int sibling(input int n, input logic nx2n);
        if (nx2n && n == 1) return 2;
        if (nx2n && n == 2) return 1;
        return n;
    endfunction

    function automatic logic [1:0] sign_frac(input int d);
        if (d == 0) return 2'b00;
        if (d > 0) return 2'b01;
        return 2'b11;
    endfunction

    // z-order index list with siblings 0 2 1 3 under a vertical split
    task automatic build_order(input logic [`FME_PART_W-1:0] part);
        int n;
        int i32, i16, i08;
        n = 0;
        for (int a = 0; a < 4; a++) begin
            i32 = sibling(a, part[1:0] == 2'd2);
            for (int b = 0; b < 4; b++) begin
                i16 = sibling(b, part[2 + 2*i32 +: 2] == 2'd2);
                for (int c = 0; c < 4; c++) begin
                    i08 = sibling(c, part[10 + 2*(i32*4 + i16) +: 2] == 2'd2);
                    order[n] = i32*16 + i16*4 + i08;
                    n++;
                end
            end
        end
    endtask

    // refined vector is the integer one moved by -1, 0 or +1
    task automatic fill_tables(input int seed);
        for (int k = 0; k < 64; k++) begin
            imv_x[k] = ((seed + k*29) % 200) - 100;
            imv_y[k] = (((seed >> 4) ^ (k*11)) % 180) - 90;
            fmv_x[k] = imv_x[k] + ((seed + k*7) % 3) - 1;
            fmv_y[k] = imv_y[k] + ((seed + k*5 + 1) % 3) - 1;
            imv_mem[k] = {imv_x[k][9:0], imv_y[k][9:0]};
            fmv_mem[k] = {fmv_x[k][9:0], fmv_y[k][9:0]};
        end
    endtask

    task automatic run_pass(input int p, input int t);
        int idx, bx, by, adr;
        for (int n = 0; n < 64; n++) begin
            idx = order[n];
            bx = ((idx >> 4) & 1)*4 + ((idx >> 2) & 1)*2 + (idx & 1);
            by = ((idx >> 5) & 1)*4 + ((idx >> 3) & 1)*2 + ((idx >> 1) & 1);
            adr = by*8 + bx;
            @(negedge clk);
            check("imv_rden_o", 64'(imv_rden_o), 64'd1);
            check("fmv_rden_o", 64'(fmv_rden_o), 64'(p));
            check("ref_rden_o", 64'(ref_rden_o), 64'd0);
            check("imv_rdaddr_o", 64'(imv_rdaddr_o), 64'(adr));
            check("fmv_rdaddr_o", 64'(fmv_rdaddr_o), 64'(adr));
            check("ip_idx_o", 64'(ip_idx_o), 64'(idx));
            if (n == 1) check("ip_idx_o", 64'(ip_idx_o), stim[t*NCOLS + 4]);
            if (n == 4) check("ip_idx_o", 64'(ip_idx_o), stim[t*NCOLS + 5]);
            for (int r = 0; r < `FME_ROWS; r++) begin
                @(negedge clk);
                check("ref_rden_o", 64'(ref_rden_o), 64'd1);
                check("imv_rden_o", 64'(imv_rden_o), 64'd0);
                check("ip_start_o", 64'(ip_start_o), 64'(r == 0));
                check("done_o", 64'(done_o), 64'd0);
                check("ref_idx_x_o", 64'(ref_idx_x_o),
                      64'(((imv_x[adr] >>> 2) + bx*8 + `FME_REF_PAD) & 255));
                check("ref_idx_y_o", 64'(ref_idx_y_o),
                      64'(((imv_y[adr] >>> 2) + by*8 + r + `FME_REF_PAD
                           - `FME_REF_ROW_OFS) & 255));
                check("ip_half_flag_o", 64'(ip_half_flag_o), 64'(p == 0));
                check("ip_mv_x_o", 64'(ip_mv_x_o),
                      64'(((p == 0) ? imv_x[adr] : fmv_x[adr]) & 1023));
                check("ip_mv_y_o", 64'(ip_mv_y_o),
                      64'(((p == 0) ? imv_y[adr] : fmv_y[adr]) & 1023));
                check("ip_frac_x_o", 64'(ip_frac_x_o),
                      64'((p == 0) ? 2'b00 : sign_frac(fmv_x[adr] - imv_x[adr])));
                check("ip_frac_y_o", 64'(ip_frac_y_o),
                      64'((p == 0) ? 2'b00 : sign_frac(fmv_y[adr] - imv_y[adr])));
            end
        end
        // nothing may move during the cost wait
        for (int w = 0; w < delay[t][p]; w++) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        #1 cost_done_i = 1'b1;
        @(negedge clk);
        expect_quiet();
        @(posedge clk);
        #1 cost_done_i = 1'b0;
    endtask

    initial begin
        rstn = 1'b0;
        start_i = 1'b0;
        cost_done_i = 1'b0;
        partition_i = '0;
        cycles = 0;
        limit = 0;
        seed_ret = $urandom(32'h6f04_3b93);
        $readmemh("tests/fme_stimulus.txt", stim);
        for (int t = 0; t < NTESTS; t++) begin
            for (int p = 0; p < 2; p++) begin
                delay[t][p] = int'(stim[t*NCOLS + 2 + p]);
                if (delay[t][p] == 0) delay[t][p] = 1 + int'($urandom % 32);
                limit += delay[t][p];
            end
            limit += 2176 + 20;
        end
        limit += 60;  // reset and idle checks
        for (int k = 0; k < 64; k++) begin
            imv_mem[k] = '0;
            fmv_mem[k] = '0;
        end
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
        // idle with no start
        repeat (20) begin
            @(negedge clk);
            expect_quiet();
        end
        for (int t = 0; t < NTESTS; t++) begin
            @(posedge clk);
            #1;
            partition_i = `FME_PART_W'(stim[t*NCOLS]);
            fill_tables(int'(stim[t*NCOLS + 1]));
            build_order(partition_i);
            start_i = 1'b1;
            @(posedge clk);
            #1 start_i = 1'b0;
            run_pass(0, t);
            run_pass(1, t);
            @(negedge clk);
            check("done_o", 64'(done_o), 64'd1);
            @(negedge clk);
            expect_quiet();
        end
        if (fme_ctrl_top_inst.fme_ctrl_sva_inst.fail_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("ERROR: a bound assertion on the DUT strobes failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tests/fme_ctrl_sva.sv */
/*
 * concurrent checks on the read strobes and the done pulse
 * bound to fme_ctrl_top and silent while rstn is low
 */
`default_nettype none

module fme_ctrl_sva (
    input wire logic clk,
    input wire logic rstn,
    input wire logic rden_i,      // vector read strobe
    input wire logic ref_rden_i,
    input wire logic ip_start_i,
    input wire logic done_i
);

    int fail_cnt = 0;  // failed assertions so far

    // ************************************************************
    // strobe relations
    // ************************************************************
    rd_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(rden_i && ref_rden_i))
        else begin
            $error("vector read and reference read high together");
            fail_cnt++;
        end

    start_dly: assert property (@(posedge clk) disable iff (!rstn)
        ip_start_i == $past(rden_i))
        else begin
            $error("ip_start is not the read strobe delayed one cycle");
            fail_cnt++;
        end

    rd_single: assert property (@(posedge clk) disable iff (!rstn)
        rden_i |=> !rden_i)
        else begin
            $error("vector read strobe longer than one cycle");
            fail_cnt++;
        end

    // done closes the quarter wait for one cycle only
    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done_i |=> !done_i)
        else begin
            $error("done is longer than one cycle");
            fail_cnt++;
        end

endmodule

bind fme_ctrl_top fme_ctrl_sva fme_ctrl_sva_inst (
    .clk        (clk),
    .rstn       (rstn),
    .rden_i     (imv_rden_o),
    .ref_rden_i (ref_rden_o),
    .ip_start_i (ip_start_o),
    .done_i     (done_o)
);

`default_nettype wire

/* hdl/fme_ctrl_top.sv */
/*
 * fractional ME controller top: phase FSM, block walker, vector router
 * vector memories must answer combinationally while rden is high
 */
`include "fme_consts.svh"
`default_nettype none

module fme_ctrl_top (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        start_i,
    output logic                             done_o,
    input  wire logic [`FME_PART_W-1:0]      partition_i,
    output logic                             imv_rden_o,
    output logic [`FME_BLK_W-1:0]            imv_rdaddr_o,
    input  wire logic [2*`FME_MV_W-1:0]      imv_data_i,
    output logic                             fmv_rden_o,
    output logic [`FME_BLK_W-1:0]            fmv_rdaddr_o,
    input  wire logic [2*`FME_MV_W-1:0]      fmv_data_i,
    output logic                             ref_rden_o,
    output logic [`FME_REF_W-1:0]            ref_idx_x_o,
    output logic [`FME_REF_W-1:0]            ref_idx_y_o,
    output logic                             ip_start_o,
    output logic [`FME_MV_W-1:0]             ip_mv_x_o,
    output logic [`FME_MV_W-1:0]             ip_mv_y_o,
    output logic [1:0]                       ip_frac_x_o,
    output logic [1:0]                       ip_frac_y_o,
    output logic                             ip_half_flag_o,
    output logic [`FME_BLK_W-1:0]            ip_idx_o,
    input  wire logic                        cost_done_i
);

    fme_ctrl_pkg::fme_state_e    state;
    fme_part_pkg::blk_addr_t     rd_addr;
    logic [`FME_CNT_W-1:0]       cnt32;
    logic [`FME_CNT_W-1:0]       cnt16;
    logic [`FME_CNT_W-1:0]       cnt08;
    logic [`FME_ROW_W-1:0]       row;
    logic                        mv_rden;
    logic                        pass_last;

    fme_phase_fsm fme_phase_fsm_inst (
        .clk         (clk),
        .rstn        (rstn),
        .start_i     (start_i),
        .cost_done_i (cost_done_i),
        .pass_last_i (pass_last),
        .state_o     (state),
        .done_o      (done_o)
    );

    fme_blk_walker fme_blk_walker_inst (
        .clk         (clk),
        .rstn        (rstn),
        .state_i     (state),
        .partition_i (partition_i),
        .cnt32_o     (cnt32),
        .cnt16_o     (cnt16),
        .cnt08_o     (cnt08),
        .row_o       (row),
        .mv_rden_o   (mv_rden),
        .ref_rden_o  (ref_rden_o),
        .ip_start_o  (ip_start_o),
        .pass_last_o (pass_last)
    );

    fme_mv_route fme_mv_route_inst (
        .state_i        (state),
        .cnt32_i        (cnt32),
        .cnt16_i        (cnt16),
        .cnt08_i        (cnt08),
        .row_i          (row),
        .imv_data_i     (imv_data_i),
        .fmv_data_i     (fmv_data_i),
        .rdaddr_o       (rd_addr),
        .ip_mv_x_o      (ip_mv_x_o),
        .ip_mv_y_o      (ip_mv_y_o),
        .ip_frac_x_o    (ip_frac_x_o),
        .ip_frac_y_o    (ip_frac_y_o),
        .ip_half_flag_o (ip_half_flag_o),
        .ip_idx_o       (ip_idx_o),
        .ref_idx_x_o    (ref_idx_x_o),
        .ref_idx_y_o    (ref_idx_y_o)
    );

    // both memories share one address
    assign imv_rden_o   = mv_rden;
    assign imv_rdaddr_o = rd_addr;
    assign fmv_rdaddr_o = rd_addr;

    // refined vectors exist only for the quarter pass
    assign fmv_rden_o = mv_rden && ((state == fme_ctrl_pkg::PRE_QUAR) ||
                                    (state == fme_ctrl_pkg::QUAR));

endmodule

`default_nettype wire

/* hdl/fme_mv_route.sv */
/*
 * picks the vector for interpolation and forms the reference indices
 * purely combinational; vector data must be valid while the address is held
 * fraction is a sign only, the refined vector is assumed within one step
 */
`include "fme_consts.svh"
`default_nettype none

module fme_mv_route (
    input  wire fme_ctrl_pkg::fme_state_e    state_i,
    input  wire logic [`FME_CNT_W-1:0]       cnt32_i,
    input  wire logic [`FME_CNT_W-1:0]       cnt16_i,
    input  wire logic [`FME_CNT_W-1:0]       cnt08_i,
    input  wire logic [`FME_ROW_W-1:0]       row_i,
    input  wire logic [2*`FME_MV_W-1:0]      imv_data_i,
    input  wire logic [2*`FME_MV_W-1:0]      fmv_data_i,
    output fme_part_pkg::blk_addr_t          rdaddr_o,
    output logic [`FME_MV_W-1:0]             ip_mv_x_o,
    output logic [`FME_MV_W-1:0]             ip_mv_y_o,
    output logic [1:0]                       ip_frac_x_o,
    output logic [1:0]                       ip_frac_y_o,
    output logic                             ip_half_flag_o,
    output logic [`FME_BLK_W-1:0]            ip_idx_o,
    output logic [`FME_REF_W-1:0]            ref_idx_x_o,
    output logic [`FME_REF_W-1:0]            ref_idx_y_o
);

    logic signed [`FME_MV_W-1:0] imv_x;
    logic signed [`FME_MV_W-1:0] imv_y;
    logic signed [`FME_MV_W-1:0] fmv_x;
    logic signed [`FME_MV_W-1:0] fmv_y;
    logic signed [`FME_MV_W:0]   dmv_x;  // one extra bit, no overflow
    logic signed [`FME_MV_W:0]   dmv_y;

    // 00 none, 01 forward, 11 backward
    function automatic logic [1:0] frac_of(input logic signed [`FME_MV_W:0] d);
        logic [1:0] f;
        if (d == 0) begin
            f = 2'b00;
        end else if (d > 0) begin
            f = 2'b01;
        end else begin
            f = 2'b11;
        end
        return f;
    endfunction

    // ************************************************************
    // block address
    // ************************************************************
    assign rdaddr_o.y = {cnt32_i[1], cnt16_i[1], cnt08_i[1]};
    assign rdaddr_o.x = {cnt32_i[0], cnt16_i[0], cnt08_i[0]};
    assign ip_idx_o   = {cnt32_i, cnt16_i, cnt08_i};  // z-order index

    // ************************************************************
    // vector select and fraction
    // ************************************************************
    assign imv_x = imv_data_i[2*`FME_MV_W-1:`FME_MV_W];  // x in upper half
    assign imv_y = imv_data_i[`FME_MV_W-1:0];
    assign fmv_x = fmv_data_i[2*`FME_MV_W-1:`FME_MV_W];
    assign fmv_y = fmv_data_i[`FME_MV_W-1:0];

    assign ip_half_flag_o = (state_i == fme_ctrl_pkg::HALF) ||
                            (state_i == fme_ctrl_pkg::DONE_HALF);

    assign dmv_x = fmv_x - imv_x;
    assign dmv_y = fmv_y - imv_y;

    assign ip_mv_x_o   = ip_half_flag_o ? imv_x : fmv_x;
    assign ip_mv_y_o   = ip_half_flag_o ? imv_y : fmv_y;
    assign ip_frac_x_o = ip_half_flag_o ? 2'b00 : frac_of(dmv_x);
    assign ip_frac_y_o = ip_half_flag_o ? 2'b00 : frac_of(dmv_y);

    // ************************************************************
    // reference pixel index, integer part of imv plus block origin
    // ************************************************************
    assign ref_idx_x_o = imv_x[`FME_MV_W-1:2]
                       + `FME_REF_W'({rdaddr_o.x, 3'b000})
                       + `FME_REF_W'(`FME_REF_PAD);

    assign ref_idx_y_o = imv_y[`FME_MV_W-1:2]
                       + `FME_REF_W'({rdaddr_o.y, 3'b000})
                       + `FME_REF_W'(row_i)
                       + `FME_REF_W'(`FME_REF_PAD - `FME_REF_ROW_OFS);

endmodule

`default_nettype wire

/* hdl/fme_blk_walker.sv */
/*
 * walks the 64 blocks of the CU in partition order, 17 cycles each:
 * one vector read, then 16 reference rows
 * partition_i must stay stable from start until done
 */
`include "fme_consts.svh"
`default_nettype none

module fme_blk_walker (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire fme_ctrl_pkg::fme_state_e    state_i,
    input  wire logic [`FME_PART_W-1:0]      partition_i,
    output logic [`FME_CNT_W-1:0]            cnt32_o,
    output logic [`FME_CNT_W-1:0]            cnt16_o,
    output logic [`FME_CNT_W-1:0]            cnt08_o,
    output logic [`FME_ROW_W-1:0]            row_o,
    output logic                             mv_rden_o,
    output logic                             ref_rden_o,
    output logic                             ip_start_o,
    output logic                             pass_last_o
);

    fme_part_pkg::part_mode_e mode64;
    fme_part_pkg::part_mode_e mode32;
    fme_part_pkg::part_mode_e mode16;
    fme_part_pkg::part_mode_e part32 [4];
    fme_part_pkg::part_mode_e part16 [16];

    logic is_pre;
    logic is_pass;
    logic is_wait;   // IDLE or a DONE state
    logic blk_end;   // last row of the current block

    // sibling order, 0 2 1 3 under a vertical split
    function automatic logic [`FME_CNT_W-1:0] next_idx(input logic [`FME_CNT_W-1:0] cur,
                                                       input logic nx2n);
        logic [`FME_CNT_W-1:0] nxt;
        case (cur)
            2'd0:    nxt = nx2n ? 2'd2 : 2'd1;
            2'd1:    nxt = nx2n ? 2'd3 : 2'd2;
            2'd2:    nxt = nx2n ? 2'd1 : 2'd3;
            default: nxt = 2'd0;
        endcase
        return nxt;
    endfunction

    // ************************************************************
    // partition decode
    // ************************************************************
    always_comb begin
        mode64 = fme_part_pkg::part_mode_e'(partition_i[1:0]);
        for (int i = 0; i < 4; i++) begin
            part32[i] = fme_part_pkg::part_mode_e'(partition_i[2 + 2*i +: 2]);
        end
        for (int j = 0; j < 16; j++) begin
            part16[j] = fme_part_pkg::part_mode_e'(partition_i[10 + 2*j +: 2]);
        end
        mode32 = part32[cnt32_o];             // mode of the enclosing 32x32
        mode16 = part16[{cnt32_o, cnt16_o}];  // mode of the enclosing 16x16
    end

    assign is_pre  = (state_i == fme_ctrl_pkg::PRE_HALF) || (state_i == fme_ctrl_pkg::PRE_QUAR);
    assign is_pass = (state_i == fme_ctrl_pkg::HALF) || (state_i == fme_ctrl_pkg::QUAR);
    assign is_wait = !is_pre && !is_pass;

    // ************************************************************
    // strobes
    // ************************************************************
    assign mv_rden_o   = is_pre || (is_pass && (row_o == '0) && !ip_start_o);
    assign ref_rden_o  = is_pass && !mv_rden_o;
    assign blk_end     = ref_rden_o && (row_o == `FME_ROW_W'(`FME_ROWS - 1));
    assign pass_last_o = blk_end && (cnt32_o == 2'd3) && (cnt16_o == 2'd3) && (cnt08_o == 2'd3);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ip_start_o <= 1'b0;
        end else begin
            ip_start_o <= mv_rden_o;
        end
    end

    // row count restarts on every vector read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_o <= '0;
        end else if (is_wait || mv_rden_o) begin
            row_o <= '0;
        end else begin
            row_o <= row_o + 1'b1;
        end
    end

    // ************************************************************
    // block counters, 8 level innermost
    // ************************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt32_o <= '0;
            cnt16_o <= '0;
            cnt08_o <= '0;
        end else if (is_wait) begin
            cnt32_o <= '0;
            cnt16_o <= '0;
            cnt08_o <= '0;
        end else if (blk_end) begin
            cnt08_o <= next_idx(cnt08_o, mode16 == fme_part_pkg::PART_NX2N);
            if (cnt08_o == 2'd3) begin
                cnt16_o <= next_idx(cnt16_o, mode32 == fme_part_pkg::PART_NX2N);
                if (cnt16_o == 2'd3) begin
                    cnt32_o <= next_idx(cnt32_o, mode64 == fme_part_pkg::PART_NX2N);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fme_phase_fsm.sv */
/*
 * pass sequencer: IDLE, half pass, quarter pass, back to IDLE
 * start_i is ignored outside IDLE; cost_done_i only counts in DONE states
 */
`default_nettype none

module fme_phase_fsm (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     start_i,
    input  wire logic                     cost_done_i,
    input  wire logic                     pass_last_i,  // last row of block 63
    output fme_ctrl_pkg::fme_state_e      state_o,
    output logic                          done_o
);

    fme_ctrl_pkg::fme_state_e next_state;

    // ************************************************************
    // next state
    // ************************************************************
    always_comb begin
        next_state = state_o;
        case (state_o)
            fme_ctrl_pkg::IDLE: begin
                if (start_i) begin
                    next_state = fme_ctrl_pkg::PRE_HALF;
                end
            end
            fme_ctrl_pkg::PRE_HALF: next_state = fme_ctrl_pkg::HALF;
            fme_ctrl_pkg::HALF: begin
                if (pass_last_i) begin
                    next_state = fme_ctrl_pkg::DONE_HALF;
                end
            end
            fme_ctrl_pkg::DONE_HALF: begin
                if (cost_done_i) begin
                    next_state = fme_ctrl_pkg::PRE_QUAR;
                end
            end
            fme_ctrl_pkg::PRE_QUAR: next_state = fme_ctrl_pkg::QUAR;
            fme_ctrl_pkg::QUAR: begin
                if (pass_last_i) begin
                    next_state = fme_ctrl_pkg::DONE_QUAR;
                end
            end
            fme_ctrl_pkg::DONE_QUAR: begin
                if (cost_done_i) begin
                    next_state = fme_ctrl_pkg::IDLE;
                end
            end
            default: next_state = fme_ctrl_pkg::IDLE;
        endcase
    end

    // ************************************************************
    // state and done registers
    // ************************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_o <= fme_ctrl_pkg::IDLE;
        end else begin
            state_o <= next_state;
        end
    end

    // one pulse as the quarter wait closes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_o <= 1'b0;
        end else begin
            done_o <= (state_o == fme_ctrl_pkg::DONE_QUAR) && cost_done_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/fme_ctrl_pkg.sv */
/*
 * phase states of the fractional ME controller
 * half pass then quarter pass, each with a one-cycle PRE state
 */
`default_nettype none

package fme_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        PRE_HALF  = 3'd1,  // first vector read of the half pass
        HALF      = 3'd2,
        DONE_HALF = 3'd3,  // wait for cost stage
        PRE_QUAR  = 3'd4,  // first vector read of the quarter pass
        QUAR      = 3'd5,
        DONE_QUAR = 3'd6   // wait for cost stage, then done
    } fme_state_e;

endpackage

`default_nettype wire

/* hdl/fme_part_pkg.sv */
/*
 * partition modes from integer ME and the 8x8 block address
 * block address is y above x, three bits each for a 64x64 CU
 */
`default_nettype none

package fme_part_pkg;

    // encoding matches the partition vector from integer ME
    typedef enum logic [1:0] {
        PART_2NX2N = 2'd0,
        PART_2NXN  = 2'd1,
        PART_NX2N  = 2'd2,
        PART_SPLIT = 2'd3
    } part_mode_e;

    // bit k of y and x comes from the level counter at that depth,
    // msb from the 32 level, lsb from the 8 level
    typedef struct packed {
        logic [2:0] y;  // block row
        logic [2:0] x;  // block column
    } blk_addr_t;

endpackage

`default_nettype wire

/* hdl/fme_consts.svh */
/*
 * shared sizes for the fractional ME controller
 * sized for one 64x64 CU of 8x8 blocks; vectors are quarter-pel,
 * two signed components packed x over y in one memory word
 */
`ifndef FME_CONSTS_SVH
`define FME_CONSTS_SVH

// ************************************************************
// vector and counter widths
// ************************************************************
`define FME_MV_W        10  // one signed mv component, quarter-pel
`define FME_CNT_W       2   // index at the 32, 16 and 8 levels
`define FME_ROW_W       4   // reference row counter
`define FME_BLK_W       6   // 8x8 block address inside the CU
`define FME_ROWS        16  // reference rows fetched per block

// ************************************************************
// partition and reference window
// ************************************************************
`define FME_PART_W      42  // 1 + 4 + 16 two-bit modes
`define FME_REF_W       8   // reference pixel index
`define FME_REF_PAD     60  // search margin added to every index
`define FME_REF_ROW_OFS 32  // window is shifted up by this many rows

`endif
